// File: source/mmu_pkg.sv
// MMU shared types
package mmu_pkg;

    // One half of a TLB entry, EntryLo without the G bit
    typedef struct packed {
        logic [19:0] pfn;
        logic [2:0]  c;
        logic        d;
        logic        v;
    } tlb_page_t;

    typedef struct packed {
        logic [11:0] mask;
        logic [18:0] vpn2;
        logic [7:0]  asid;
        logic        g;
        tlb_page_t   page0;
        tlb_page_t   page1;
    } tlb_entry_t;

    typedef struct packed {
        logic       kernel;
        logic       erl;
        logic       kseg0_cached;
        logic [7:0] asid;
    } cpu_mode_t;

    typedef struct packed {
        logic [31:0] pa;
        logic        hit;
        logic        valid;
        logic        dirty;
        logic        cached;
        logic        addr_err;
    } xlat_resp_t;

    typedef enum logic [1:0] {
        NONE,
        WRITE,
        READ,
        PROBE
    } tlb_cmd_t;

    // Word addresses on the register bus
    localparam logic [2:0] REG_INDEX    = 3'd0;
    localparam logic [2:0] REG_ENTRYHI  = 3'd1;
    localparam logic [2:0] REG_ENTRYLO0 = 3'd2;
    localparam logic [2:0] REG_ENTRYLO1 = 3'd3;
    localparam logic [2:0] REG_PAGEMASK = 3'd4;
    localparam logic [2:0] REG_STATUS   = 3'd5;
    localparam logic [2:0] REG_CMD      = 3'd6;

endpackage

// File: source/tlb_csr_wb.sv
// TLB register block on Wishbone
`timescale 1ns/1ps

module tlb_csr_wb #(
    parameter int TLB_IDX_BITS = 3
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wb_cyc_i,
    input  logic                    wb_stb_i,
    input  logic                    wb_we_i,
    input  logic [2:0]              wb_adr_i,
    input  logic [31:0]             wb_dat_i,
    output logic [31:0]             wb_dat_o,
    output logic                    wb_ack_o,
    output mmu_pkg::tlb_cmd_t       cmd_o,
    output logic [TLB_IDX_BITS-1:0] sel_index_o,
    output mmu_pkg::tlb_entry_t     wr_entry_o,
    input  mmu_pkg::tlb_entry_t     rd_entry_i,
    input  logic                    probe_hit_i,
    input  logic [TLB_IDX_BITS-1:0] probe_index_i,
    output mmu_pkg::cpu_mode_t      mode_o
);
    import mmu_pkg::*;

    logic                    ack_q;
    logic                    req;
    tlb_cmd_t                cmd_q;
    logic                    probe_fail_q;
    logic [TLB_IDX_BITS-1:0] index_q;
    logic [18:0]             hi_vpn2_q;
    logic [7:0]              hi_asid_q;
    logic [25:0]             lo0_q;
    logic [25:0]             lo1_q;
    logic [11:0]             mask_q;
    // kseg0_cached, erl, kernel
    logic [2:0]              status_q;

    // EntryLo layout is pfn[25:6] c[5:3] d[2] v[1] g[0]
    function automatic tlb_page_t page_from_lo(input logic [25:0] lo, input logic [11:0] mask);
        tlb_page_t pg;
        pg.pfn = lo[25:6] & {8'hff, ~mask};
        pg.c   = lo[5:3];
        pg.d   = lo[2];
        pg.v   = lo[1];
        return pg;
    endfunction

    function automatic logic [25:0] lo_from_page(input tlb_page_t pg, input logic g);
        return {pg.pfn, pg.c, pg.d, pg.v, g};
    endfunction

    // New access only when no ack is pending
    assign req = wb_cyc_i && wb_stb_i && !ack_q;

    assign wb_ack_o    = ack_q;
    assign cmd_o       = cmd_q;
    assign sel_index_o = index_q;

    always_comb begin
        wr_entry_o.mask  = mask_q;
        wr_entry_o.vpn2  = hi_vpn2_q & {7'h7f, ~mask_q};
        wr_entry_o.asid  = hi_asid_q;
        wr_entry_o.g     = lo0_q[0] & lo1_q[0];
        wr_entry_o.page0 = page_from_lo(lo0_q, mask_q);
        wr_entry_o.page1 = page_from_lo(lo1_q, mask_q);
    end

    assign mode_o = '{kernel: status_q[0], erl: status_q[1], kseg0_cached: status_q[2],
                      asid: hi_asid_q};

    // Read data follows the held address
    always_comb begin
        case (wb_adr_i)
            REG_INDEX:    wb_dat_o = {probe_fail_q, {(31 - TLB_IDX_BITS){1'b0}}, index_q};
            REG_ENTRYHI:  wb_dat_o = {hi_vpn2_q, 5'b0, hi_asid_q};
            REG_ENTRYLO0: wb_dat_o = {6'b0, lo0_q};
            REG_ENTRYLO1: wb_dat_o = {6'b0, lo1_q};
            REG_PAGEMASK: wb_dat_o = {7'b0, mask_q, 13'b0};
            REG_STATUS:   wb_dat_o = {29'b0, status_q};
            default:      wb_dat_o = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q        <= 1'b0;
            cmd_q        <= NONE;
            probe_fail_q <= 1'b0;
            index_q      <= '0;
            hi_vpn2_q    <= '0;
            hi_asid_q    <= '0;
            lo0_q        <= '0;
            lo1_q        <= '0;
            mask_q       <= '0;
            status_q     <= '0;
        end else begin
            ack_q <= req;
            cmd_q <= NONE;
            if (req && wb_we_i) begin
                case (wb_adr_i)
                    REG_INDEX: begin
                        probe_fail_q <= wb_dat_i[31];
                        index_q      <= wb_dat_i[TLB_IDX_BITS-1:0];
                    end
                    REG_ENTRYHI: begin
                        hi_vpn2_q <= wb_dat_i[31:13];
                        hi_asid_q <= wb_dat_i[7:0];
                    end
                    REG_ENTRYLO0: lo0_q    <= wb_dat_i[25:0];
                    REG_ENTRYLO1: lo1_q    <= wb_dat_i[25:0];
                    REG_PAGEMASK: mask_q   <= wb_dat_i[24:13];
                    REG_STATUS:   status_q <= wb_dat_i[2:0];
                    REG_CMD:      cmd_q    <= tlb_cmd_t'(wb_dat_i[1:0]);
                    default: ;
                endcase
            end
            // Command runs during the ack cycle, results land at its end
            case (cmd_q)
                READ: begin
                    hi_vpn2_q <= rd_entry_i.vpn2;
                    hi_asid_q <= rd_entry_i.asid;
                    lo0_q     <= lo_from_page(rd_entry_i.page0, rd_entry_i.g);
                    lo1_q     <= lo_from_page(rd_entry_i.page1, rd_entry_i.g);
                    mask_q    <= rd_entry_i.mask;
                end
                PROBE: begin
                    probe_fail_q <= !probe_hit_i;
                    index_q      <= probe_index_i;
                end
                default: ;
            endcase
        end
    end

endmodule

// File: source/tlb_array.sv
// TLB entry storage
`timescale 1ns/1ps

module tlb_array #(
    parameter int TLB_IDX_BITS = 3
) (
    input  logic                                            clk,
    input  logic                                            rst,
    input  mmu_pkg::tlb_cmd_t                               cmd_i,
    input  logic [TLB_IDX_BITS-1:0]                         sel_index_i,
    input  mmu_pkg::tlb_entry_t                             wr_entry_i,
    output mmu_pkg::tlb_entry_t                             rd_entry_o,
    output logic                                            probe_hit_o,
    output logic [TLB_IDX_BITS-1:0]                         probe_index_o,
    output mmu_pkg::tlb_entry_t [(1 << TLB_IDX_BITS)-1:0]   entries_o
);
    import mmu_pkg::*;

    localparam int TLB_NUM = 1 << TLB_IDX_BITS;

    // Invalid page, cacheable attribute
    localparam tlb_page_t PAGE_RST = '{pfn: 20'h0, c: 3'd3, d: 1'b0, v: 1'b0};
    localparam tlb_entry_t ENTRY_RST = '{
        mask:  12'h0,
        vpn2:  19'h0,
        asid:  8'h0,
        g:     1'b0,
        page0: PAGE_RST,
        page1: PAGE_RST
    };

    tlb_entry_t [TLB_NUM-1:0]  entries_q;
    logic [TLB_NUM-1:0]        probe_match;
    logic [TLB_IDX_BITS-1:0]   probe_idx;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int n = 0; n < TLB_NUM; n++) begin
                entries_q[n] <= ENTRY_RST;
            end
        end else if (cmd_i == WRITE) begin
            entries_q[sel_index_i] <= wr_entry_i;
        end
    end

    assign entries_o  = entries_q;
    assign rd_entry_o = entries_q[sel_index_i];

    // Probe key is the EntryHi part of the write entry
    for (genvar i = 0; i < TLB_NUM; i++) begin : g_probe
        logic [18:0] keep;
        logic        vpn_eq;
        logic        asid_ok;

        assign keep    = {7'h7f, ~entries_q[i].mask};
        assign vpn_eq  = (wr_entry_i.vpn2 & keep) == (entries_q[i].vpn2 & keep);
        assign asid_ok = entries_q[i].g || (entries_q[i].asid == wr_entry_i.asid);
        assign probe_match[i] = vpn_eq && asid_ok;
    end

    // Entries never overlap, so OR of matching indices is the index
    always_comb begin
        probe_idx = '0;
        for (int i = 0; i < TLB_NUM; i++) begin
            if (probe_match[i]) begin
                probe_idx = probe_idx | TLB_IDX_BITS'(i);
            end
        end
    end

    assign probe_hit_o   = |probe_match;
    assign probe_index_o = probe_idx;

endmodule

// File: source/va_translator.sv
// Virtual to physical address translation
`timescale 1ns/1ps

module va_translator #(
    parameter int TLB_IDX_BITS = 3
) (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic                                            ce_i,
    input  logic [31:0]                                     va_i,
    input  mmu_pkg::cpu_mode_t                              mode_i,
    input  mmu_pkg::tlb_entry_t [(1 << TLB_IDX_BITS)-1:0]   entries_i,
    output mmu_pkg::xlat_resp_t                             resp_o
);
    import mmu_pkg::*;

    localparam int TLB_NUM = 1 << TLB_IDX_BITS;

    typedef enum logic [2:0] {
        SEG_USEG,
        SEG_KSEG0,
        SEG_KSEG1,
        SEG_KSSEG,
        SEG_KSEG3
    } seg_t;

    seg_t                          seg;
    logic                          mapped;
    logic                          addr_err;
    logic [TLB_NUM-1:0]            match;
    tlb_page_t [TLB_NUM-1:0]       ent_page;
    logic [TLB_NUM-1:0][31:0]      ent_pa;
    logic [31:0]                   map_pa;
    logic [2:0]                    map_c;
    logic                          map_v;
    logic                          map_d;
    xlat_resp_t                    resp_d;
    xlat_resp_t                    resp_q;

    for (genvar i = 0; i < TLB_NUM; i++) begin : g_entry
        logic [18:0] keep;
        logic        sel_odd;

        assign keep     = {7'h7f, ~entries_i[i].mask};
        assign match[i] = ((va_i[31:13] & keep) == (entries_i[i].vpn2 & keep))
                          && (entries_i[i].g || entries_i[i].asid == mode_i.asid);
        // Bit just above the masked offset picks the odd page
        assign sel_odd  = (va_i[24:12] & {entries_i[i].mask, 1'b1})
                          != (va_i[24:12] & {1'b0, entries_i[i].mask});
        assign ent_page[i] = sel_odd ? entries_i[i].page1 : entries_i[i].page0;
        assign ent_pa[i]   = {ent_page[i].pfn & {8'hff, ~entries_i[i].mask}, 12'h000}
                             | (va_i & {8'h00, entries_i[i].mask, 12'hfff});
    end

    always_comb begin
        map_pa = '0;
        map_c  = '0;
        map_v  = 1'b0;
        map_d  = 1'b0;
        for (int i = 0; i < TLB_NUM; i++) begin
            if (match[i]) begin
                map_pa = map_pa | ent_pa[i];
                map_c  = map_c | ent_page[i].c;
                map_v  = map_v | ent_page[i].v;
                map_d  = map_d | ent_page[i].d;
            end
        end
    end

    always_comb begin
        case (va_i[31:29])
            3'b100:  seg = SEG_KSEG0;
            3'b101:  seg = SEG_KSEG1;
            3'b110:  seg = SEG_KSSEG;
            3'b111:  seg = SEG_KSEG3;
            default: seg = SEG_USEG;
        endcase
    end

    // Mapping and address error per segment and mode
    always_comb begin
        mapped   = 1'b0;
        addr_err = 1'b0;
        case (seg)
            SEG_USEG:             mapped = !(mode_i.kernel && mode_i.erl);
            SEG_KSEG0, SEG_KSEG1: addr_err = !mode_i.kernel;
            SEG_KSEG3: begin
                mapped   = mode_i.kernel;
                addr_err = !mode_i.kernel;
            end
            default:              addr_err = 1'b1;
        endcase
    end

    always_comb begin
        resp_d.addr_err = addr_err;
        if (mapped) begin
            resp_d.pa     = map_pa;
            resp_d.hit    = |match;
            resp_d.valid  = map_v;
            resp_d.dirty  = map_d;
            resp_d.cached = (map_c == 3'd3);
        end else begin
            resp_d.pa     = {3'b000, va_i[28:0]};
            resp_d.hit    = 1'b1;
            resp_d.valid  = 1'b1;
            resp_d.dirty  = 1'b1;
            resp_d.cached = (seg == SEG_KSEG0) && mode_i.kseg0_cached;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_q <= '0;
        end else if (ce_i) begin
            resp_q <= resp_d;
        end
    end

    assign resp_o = resp_q;

endmodule

// File: source/mmu_top.sv
// MMU top level
`timescale 1ns/1ps

module mmu_top #(
    parameter int TLB_IDX_BITS = 3
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 wb_cyc_i,
    input  logic                 wb_stb_i,
    input  logic                 wb_we_i,
    input  logic [2:0]           wb_adr_i,
    input  logic [31:0]          wb_dat_i,
    output logic [31:0]          wb_dat_o,
    output logic                 wb_ack_o,
    input  logic                 ifetch_ce_i,
    input  logic [31:0]          ifetch_va_i,
    output mmu_pkg::xlat_resp_t  ifetch_resp_o,
    input  logic                 data_ce_i,
    input  logic [31:0]          data_va_i,
    output mmu_pkg::xlat_resp_t  data_resp_o
);
    import mmu_pkg::*;

    tlb_cmd_t                                 cmd;
    logic [TLB_IDX_BITS-1:0]                  sel_index;
    tlb_entry_t                               wr_entry;
    tlb_entry_t                               rd_entry;
    logic                                     probe_hit;
    logic [TLB_IDX_BITS-1:0]                  probe_index;
    tlb_entry_t [(1 << TLB_IDX_BITS)-1:0]     entries;
    cpu_mode_t                                mode;

    tlb_csr_wb #(.TLB_IDX_BITS(TLB_IDX_BITS)) tlb_csr_wb_i (
        .clk           (clk),
        .rst           (rst),
        .wb_cyc_i      (wb_cyc_i),
        .wb_stb_i      (wb_stb_i),
        .wb_we_i       (wb_we_i),
        .wb_adr_i      (wb_adr_i),
        .wb_dat_i      (wb_dat_i),
        .wb_dat_o      (wb_dat_o),
        .wb_ack_o      (wb_ack_o),
        .cmd_o         (cmd),
        .sel_index_o   (sel_index),
        .wr_entry_o    (wr_entry),
        .rd_entry_i    (rd_entry),
        .probe_hit_i   (probe_hit),
        .probe_index_i (probe_index),
        .mode_o        (mode)
    );

    tlb_array #(.TLB_IDX_BITS(TLB_IDX_BITS)) tlb_array_i (
        .clk           (clk),
        .rst           (rst),
        .cmd_i         (cmd),
        .sel_index_i   (sel_index),
        .wr_entry_i    (wr_entry),
        .rd_entry_o    (rd_entry),
        .probe_hit_o   (probe_hit),
        .probe_index_o (probe_index),
        .entries_o     (entries)
    );

    // Instruction fetch port
    va_translator #(.TLB_IDX_BITS(TLB_IDX_BITS)) ifetch_xlat_i (
        .clk       (clk),
        .rst       (rst),
        .ce_i      (ifetch_ce_i),
        .va_i      (ifetch_va_i),
        .mode_i    (mode),
        .entries_i (entries),
        .resp_o    (ifetch_resp_o)
    );

    va_translator #(.TLB_IDX_BITS(TLB_IDX_BITS)) data_xlat_i (
        .clk       (clk),
        .rst       (rst),
        .ce_i      (data_ce_i),
        .va_i      (data_va_i),
        .mode_i    (mode),
        .entries_i (entries),
        .resp_o    (data_resp_o)
    );

endmodule

// File: verification/mmu_asserts.sv
// Wishbone slave protocol checks
`timescale 1ns/1ps

module mmu_asserts (
    input logic               clk,
    input logic               rst,
    input logic               cyc_i,
    input logic               stb_i,
    input logic               ack_i,
    input mmu_pkg::tlb_cmd_t  cmd_i
);
    import mmu_pkg::*;

    int fail_count = 0;

    // Ack only inside an active cycle
    a_ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        ack_i |-> (cyc_i && stb_i))
        else begin
            $error("ack high without cyc and stb");
            fail_count++;
        end

    a_ack_single: assert property (@(posedge clk) disable iff (rst)
        ack_i |=> !ack_i)
        else begin
            $error("ack held for two cycles");
            fail_count++;
        end

    // Commands pulse only in the ack cycle
    a_cmd_idle: assert property (@(posedge clk) disable iff (rst)
        !ack_i |-> (cmd_i == NONE))
        else begin
            $error("command issued outside an ack cycle");
            fail_count++;
        end

endmodule

bind tlb_csr_wb mmu_asserts mmu_asserts_i (
    .clk   (clk),
    .rst   (rst),
    .cyc_i (wb_cyc_i),
    .stb_i (wb_stb_i),
    .ack_i (wb_ack_o),
    .cmd_i (cmd_o)
);

// File: verification/mmu_tb.sv
// MMU testbench
`timescale 1ns/1ps

module mmu_tb;
    import mmu_pkg::*;

    localparam int IDX_BITS    = 3;
    localparam int TLB_NUM     = 1 << IDX_BITS;
    localparam int BUS_TIMEOUT = 20;

    logic        clk;
    logic        rst;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [2:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        ifetch_ce;
    logic [31:0] ifetch_va;
    xlat_resp_t  ifetch_resp;
    logic        data_ce;
    logic [31:0] data_va;
    xlat_resp_t  data_resp;

    integer seed;
    int     err_count;
    string  test_name;

    // Reference model of the registers, entries and result registers
    tlb_entry_t          e_m [TLB_NUM];
    logic [IDX_BITS-1:0] m_index;
    logic                m_pfail;
    logic [18:0]         m_vpn2;
    logic [7:0]          m_asid;
    logic [25:0]         m_lo0;
    logic [25:0]         m_lo1;
    logic [11:0]         m_pmask;
    logic [2:0]          m_status;
    xlat_resp_t          q_if;
    xlat_resp_t          q_dt;

    // Contiguous page masks, 4K up to 16M pages
    logic [11:0] mask_set [7] = '{12'h000, 12'h003, 12'h00f, 12'h03f, 12'h0ff, 12'h3ff, 12'hfff};

    mmu_top #(.TLB_IDX_BITS(IDX_BITS)) mmu_top_i (
        .clk           (clk),
        .rst           (rst),
        .wb_cyc_i      (wb_cyc),
        .wb_stb_i      (wb_stb),
        .wb_we_i       (wb_we),
        .wb_adr_i      (wb_adr),
        .wb_dat_i      (wb_dat_w),
        .wb_dat_o      (wb_dat_r),
        .wb_ack_o      (wb_ack),
        .ifetch_ce_i   (ifetch_ce),
        .ifetch_va_i   (ifetch_va),
        .ifetch_resp_o (ifetch_resp),
        .data_ce_i     (data_ce),
        .data_va_i     (data_va),
        .data_resp_o   (data_resp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            err_count++;
            $display("** Error [%s] %s: expected 0x%h, actual 0x%h", test_name, name, exp, act);
            $display("Test failures found");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    // Request held through the ack cycle, released after it
    task automatic bus_access(input logic we, input logic [2:0] adr, input logic [31:0] wdat,
                              output logic [31:0] rdat);
        int n;
        n = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        @(posedge clk);
        #1;
        while (!wb_ack) begin
            if (n == BUS_TIMEOUT) begin
                $display("Timeout: no Wishbone ack for access to register %0d", adr);
                $display("Test failures found");
                $fatal(1, "Bus timeout");
            end
            n++;
            @(posedge clk);
            #1;
        end
        rdat = wb_dat_r;
        @(posedge clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic apply_cmd(input tlb_cmd_t cmd);
        tlb_entry_t  e;
        logic [18:0] keep;
        logic [18:0] key;
        case (cmd)
            WRITE: begin
                e.mask  = m_pmask;
                e.vpn2  = m_vpn2 & {7'h7f, ~m_pmask};
                e.asid  = m_asid;
                e.g     = m_lo0[0] & m_lo1[0];
                e.page0 = '{pfn: m_lo0[25:6] & {8'hff, ~m_pmask}, c: m_lo0[5:3],
                            d: m_lo0[2], v: m_lo0[1]};
                e.page1 = '{pfn: m_lo1[25:6] & {8'hff, ~m_pmask}, c: m_lo1[5:3],
                            d: m_lo1[2], v: m_lo1[1]};
                e_m[m_index] = e;
            end
            READ: begin
                e       = e_m[m_index];
                m_vpn2  = e.vpn2;
                m_asid  = e.asid;
                m_pmask = e.mask;
                m_lo0   = {e.page0.pfn, e.page0.c, e.page0.d, e.page0.v, e.g};
                m_lo1   = {e.page1.pfn, e.page1.c, e.page1.d, e.page1.v, e.g};
            end
            PROBE: begin
                key     = m_vpn2 & {7'h7f, ~m_pmask};
                m_pfail = 1'b1;
                for (int i = 0; i < TLB_NUM; i++) begin
                    keep = {7'h7f, ~e_m[i].mask};
                    if ((key & keep) == (e_m[i].vpn2 & keep)
                            && (e_m[i].g || e_m[i].asid == m_asid)) begin
                        m_pfail = 1'b0;
                        m_index = IDX_BITS'(i);
                    end
                end
            end
            default: ;
        endcase
    endtask

    task automatic write_reg(input logic [2:0] adr, input logic [31:0] dat);
        logic [31:0] rd_ignored;
        bus_access(1'b1, adr, dat, rd_ignored);
        case (adr)
            REG_INDEX: begin
                m_pfail = dat[31];
                m_index = dat[IDX_BITS-1:0];
            end
            REG_ENTRYHI: begin
                m_vpn2 = dat[31:13];
                m_asid = dat[7:0];
            end
            REG_ENTRYLO0: m_lo0    = dat[25:0];
            REG_ENTRYLO1: m_lo1    = dat[25:0];
            REG_PAGEMASK: m_pmask  = dat[24:13];
            REG_STATUS:   m_status = dat[2:0];
            REG_CMD:      apply_cmd(tlb_cmd_t'(dat[1:0]));
            default: ;
        endcase
    endtask

    function automatic logic [31:0] reg_word(input logic [2:0] adr);
        case (adr)
            REG_INDEX:    return {m_pfail, {(31 - IDX_BITS){1'b0}}, m_index};
            REG_ENTRYHI:  return {m_vpn2, 5'h0, m_asid};
            REG_ENTRYLO0: return {6'h0, m_lo0};
            REG_ENTRYLO1: return {6'h0, m_lo1};
            REG_PAGEMASK: return {7'h0, m_pmask, 13'h0};
            REG_STATUS:   return {29'h0, m_status};
            default:      return 32'h0;
        endcase
    endfunction

    task automatic read_check(input logic [2:0] adr, input string name);
        logic [31:0] rd;
        bus_access(1'b0, adr, 32'h0, rd);
        check(name, {32'h0, reg_word(adr)}, {32'h0, rd});
    endtask

    function automatic xlat_resp_t model_xlat(input logic [31:0] va);
        xlat_resp_t  r;
        logic [2:0]  seg;
        logic        kernel;
        logic [18:0] keep;
        int          odd_bit;
        tlb_page_t   pg;
        r      = '0;
        seg    = va[31:29];
        kernel = m_status[0];
        // ksseg always faults, upper kernel segments fault outside kernel mode
        r.addr_err = (seg == 3'b110) || (seg[2] && !kernel);
        if (kernel && (seg == 3'b100 || seg == 3'b101 || (!seg[2] && m_status[1]))) begin
            r.pa     = {3'b000, va[28:0]};
            r.hit    = 1'b1;
            r.valid  = 1'b1;
            r.dirty  = 1'b1;
            r.cached = (seg == 3'b100) && m_status[2];
            return r;
        end
        for (int i = 0; i < TLB_NUM; i++) begin
            keep = {7'h7f, ~e_m[i].mask};
            if (!r.hit && (va[31:13] & keep) == (e_m[i].vpn2 & keep)
                    && (e_m[i].g || e_m[i].asid == m_asid)) begin
                odd_bit = 12;
                for (int b = 0; b < 12; b++) begin
                    if (e_m[i].mask[b]) begin
                        odd_bit++;
                    end
                end
                pg       = va[odd_bit] ? e_m[i].page1 : e_m[i].page0;
                r.pa     = {pg.pfn, 12'h000} | (va & ((32'h1 << odd_bit) - 32'h1));
                r.hit    = 1'b1;
                r.valid  = pg.v;
                r.dirty  = pg.d;
                r.cached = (pg.c == 3'd3);
            end
        end
        return r;
    endfunction

    // Only addr_err is defined when it is set
    function automatic logic [63:0] resp_view(input xlat_resp_t r, input logic err_only);
        if (err_only) begin
            return {63'h0, r.addr_err};
        end
        return {27'h0, r};
    endfunction

    task automatic step_ports(input logic ce_a, input logic [31:0] va_a,
                              input logic ce_b, input logic [31:0] va_b);
        ifetch_ce = ce_a;
        ifetch_va = va_a;
        data_ce   = ce_b;
        data_va   = va_b;
        if (ce_a) begin
            q_if = model_xlat(va_a);
        end
        if (ce_b) begin
            q_dt = model_xlat(va_b);
        end
        @(posedge clk);
        #1;
        ifetch_ce = 1'b0;
        data_ce   = 1'b0;
        check("ifetch result", resp_view(q_if, q_if.addr_err),
              resp_view(ifetch_resp, q_if.addr_err));
        check("data result", resp_view(q_dt, q_dt.addr_err), resp_view(data_resp, q_dt.addr_err));
    endtask

    // VPN2 bits 17..15 carry the index so entries never overlap
    task automatic install_entry(input int idx);
        logic [31:0] hi;
        logic [11:0] mask;
        hi        = $random(seed);
        hi[30:28] = idx[2:0];
        hi[7:0]   = {6'h0, 2'($random(seed))};
        mask      = mask_set[$unsigned($random(seed)) % 7];
        write_reg(REG_INDEX, idx);
        write_reg(REG_ENTRYHI, hi);
        write_reg(REG_ENTRYLO0, $random(seed));
        write_reg(REG_ENTRYLO1, $random(seed));
        write_reg(REG_PAGEMASK, {7'h0, mask, 13'h0});
        write_reg(REG_CMD, {30'h0, WRITE});
    endtask

    function automatic logic [31:0] biased_va();
        int          k;
        logic [1:0]  pick;
        logic [31:0] r;
        k    = $unsigned($random(seed)) % TLB_NUM;
        pick = 2'($random(seed));
        r    = $random(seed);
        if (pick == 2'b00) begin
            return r;
        end
        return {e_m[k].vpn2, 13'h0} | (r & {7'h0, e_m[k].mask, 13'h1fff});
    endfunction

    initial begin
        logic [31:0] rd;
        seed      = 32'h2c1b328f;
        err_count = 0;
        test_name = "init";
        rst       = 1'b1;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = 3'h0;
        wb_dat_w  = 32'h0;
        ifetch_ce = 1'b0;
        ifetch_va = 32'h0;
        data_ce   = 1'b0;
        data_va   = 32'h0;
        m_index   = '0;
        m_pfail   = 1'b0;
        m_vpn2    = '0;
        m_asid    = '0;
        m_lo0     = '0;
        m_lo1     = '0;
        m_pmask   = '0;
        m_status  = '0;
        q_if      = '0;
        q_dt      = '0;
        for (int i = 0; i < TLB_NUM; i++) begin
            e_m[i] = '{mask: 12'h0, vpn2: 19'h0, asid: 8'h0, g: 1'b0,
                       page0: '{pfn: 20'h0, c: 3'd3, d: 1'b0, v: 1'b0},
                       page1: '{pfn: 20'h0, c: 3'd3, d: 1'b0, v: 1'b0}};
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        test_name = "reset state";
        for (int a = 0; a < 6; a++) begin
            read_check(3'(a), $sformatf("register %0d", a));
        end
        repeat (8) step_ports(1'b1, {2'b01, 30'($random(seed))}, 1'b1, {2'b01, 30'($random(seed))});

        test_name = "entry write and read back";
        for (int i = 0; i < TLB_NUM; i++) begin
            install_entry(i);
        end
        repeat (8) install_entry($unsigned($random(seed)) % TLB_NUM);
        for (int i = 0; i < TLB_NUM; i++) begin
            write_reg(REG_INDEX, i);
            write_reg(REG_CMD, {30'h0, READ});
            read_check(REG_ENTRYHI, "EntryHi");
            read_check(REG_ENTRYLO0, "EntryLo0");
            read_check(REG_ENTRYLO1, "EntryLo1");
            read_check(REG_PAGEMASK, "PageMask");
        end

        test_name = "probe";
        write_reg(REG_PAGEMASK, 32'h0);
        for (int i = 0; i < TLB_NUM; i++) begin
            write_reg(REG_ENTRYHI, {e_m[i].vpn2 | (19'($random(seed)) & {7'h0, e_m[i].mask}),
                                   5'($random(seed)),
                                   e_m[i].g ? 8'($random(seed)) : e_m[i].asid});
            write_reg(REG_CMD, {30'h0, PROBE});
            read_check(REG_INDEX, "hit index");
            write_reg(REG_ENTRYHI, {~e_m[i].vpn2[18], e_m[i].vpn2[17:0], 5'h0, 8'($random(seed))});
            write_reg(REG_CMD, {30'h0, PROBE});
            bus_access(1'b0, REG_INDEX, 32'h0, rd);
            check("miss flag", {63'h0, m_pfail}, {63'h0, rd[31]});
        end

        test_name = "mapped translation";
        for (int r = 0; r < 6; r++) begin
            write_reg(REG_STATUS, {31'h0, 1'($random(seed))});
            write_reg(REG_ENTRYHI, {24'($random(seed)), 6'h0, 2'($random(seed))});
            repeat (40) step_ports(2'($random(seed)) != 2'b00, biased_va(),
                                   2'($random(seed)) != 2'b00, biased_va());
        end

        test_name = "segments and modes";
        for (int r = 0; r < 8; r++) begin
            write_reg(REG_STATUS, {29'h0, 3'($random(seed))});
            write_reg(REG_ENTRYHI, {24'($random(seed)), 6'h0, 2'($random(seed))});
            repeat (30) step_ports(1'b1, $random(seed), 1'b1, biased_va());
        end

        test_name = "hold without enable";
        write_reg(REG_STATUS, 32'h0);
        step_ports(1'b1, biased_va(), 1'b1, biased_va());
        ifetch_va = $random(seed);
        data_va   = $random(seed);
        install_entry($unsigned($random(seed)) % TLB_NUM);
        write_reg(REG_STATUS, {29'h0, 3'($random(seed))});
        repeat (4) step_ports(1'b0, $random(seed), 1'b0, $random(seed));

        if (err_count == 0 && mmu_top_i.tlb_csr_wb_i.mmu_asserts_i.fail_count == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Test failures found");
            $fatal(1, "Checks failed");
        end
    end

endmodule

// File: project.f
source/mmu_pkg.sv
source/tlb_csr_wb.sv
source/tlb_array.sv
source/va_translator.sv
source/mmu_top.sv
verification/mmu_asserts.sv
verification/mmu_tb.sv
